// ==== all.f ====
hybche_pkg.sv
hybche_cfg_apb.sv
hybche_index_map.sv
hybche_arrays.sv
hybche_lookup.sv
hybche_flush_ctrl.sv
hybche_top.sv
tb_clk_gen.sv
tb_hybche.sv

// ==== tb_hybche.sv ====
// Model assumes 4 ways, seed 0x0A5 and FA region at sets 8..15; inputs change on falling edges
module tb_hybche;
  timeunit 1ns;
  timeprecision 100ps;
  import hybche_pkg::*;

  localparam int unsigned WAYS    = 4;
  localparam logic [8:0]  SEED    = 9'h0A5;
  localparam int unsigned FA_BASE = 8;
  localparam int unsigned FA_CNT  = 8;
  // Cycle budget per test with reset covered by the margin
  localparam int VICTIM_CYC  = 12;
  localparam int SA_CYC      = 80;
  localparam int WR_CYC      = 12;
  localparam int FA_CYC      = 20;
  localparam int APB_CYC     = 14;
  localparam int FLUSH_CYC   = 36;
  localparam int CYCLE_LIMIT = VICTIM_CYC + SA_CYC + WR_CYC + FA_CYC + APB_CYC + FLUSH_CYC + 200;

  logic clk, rst_n;
  logic psel, penable, pwrite, pready, pslverr;
  logic [7:0] paddr;
  logic [31:0] pwdata, prdata;
  logic rd_req, rd_vld, fill, flush_ack;
  hybche_addr_u rd_addr, fill_addr, wr_addr;
  logic [WAYS-1:0] rd_hit, rd_valid, wr_req_oh;
  logic [31:0] rd_data, wr_data;
  logic [63:0] fill_data;
  int cycle_cnt, err_cnt, test_err0, tests_run, tests_failed;

  //////////////////////////////
  // Reference model state
  //////////////////////////////
  logic [FA_TAG_W-1:0] m_tag  [NUM_SETS][WAYS];
  logic [LINE_W-1:0]   m_line [NUM_SETS][WAYS];
  logic [WAYS-1:0]     m_vld  [NUM_SETS];
  int                  m_rr;
  logic                m_sa;

  tb_clk_gen i_clk_gen (.clk_o (clk), .rst_no (rst_n));

  hybche_top #(
    .NUM_WAYS (WAYS), .HASH_SEED (SEED), .FA_BASE_SET (FA_BASE), .FA_SET_COUNT (FA_CNT)
  ) i_hybche_top (
    .clk_i (clk), .rst_ni (rst_n), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready),
    .pslverr_o (pslverr), .rd_req_i (rd_req), .rd_addr_i (rd_addr), .rd_vld_o (rd_vld),
    .rd_hit_oh_o (rd_hit), .rd_valid_bits_o (rd_valid), .rd_data_o (rd_data),
    .fill_i (fill), .fill_addr_i (fill_addr), .fill_data_i (fill_data),
    .wr_req_oh_i (wr_req_oh), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
    .flush_ack_o (flush_ack)
  );

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  // SA uses the index field while FA hashes the tag into the reserved region
  function automatic logic [3:0] map_set(input logic [15:0] a, input logic sa);
    logic [8:0] h;
    h = a[15:7] ^ SEED;
    if (sa) return a[6:3];
    return 4'((h % FA_CNT) + FA_BASE);
  endfunction

  function automatic logic [12:0] map_tag(input logic [15:0] a, input logic sa);
    return sa ? {4'b0, a[15:7]} : a[15:3];
  endfunction

  function automatic logic model_hit(input logic [15:0] a);
    logic [3:0] s;
    s = map_set(a, m_sa);
    for (int w = 0; w < WAYS; w++)
      if (m_vld[s][w] && m_tag[s][w] == map_tag(a, m_sa)) return 1'b1;
    return 1'b0;
  endfunction

  // Read one address and compare the registered result one cycle later
  task automatic read_check(input logic [15:0] a);
    logic [3:0] s;
    logic [WAYS-1:0] exp_hit;
    logic [31:0] exp_data;
    s = map_set(a, m_sa);
    exp_hit = '0;
    exp_data = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (m_vld[s][w] && m_tag[s][w] == map_tag(a, m_sa)) begin
        exp_hit[w] = 1'b1;
        exp_data = a[2] ? m_line[s][w][63:32] : m_line[s][w][31:0];
      end
    end
    rd_req = 1'b1;
    rd_addr = a;
    @(negedge clk);
    rd_req = 1'b0;
    if (rd_vld !== 1'b1) begin
      $display("ERROR rd_vld_o: expected 1, got %h (addr %h)", rd_vld, a);
      err_cnt++;
    end
    if (rd_hit !== exp_hit) begin
      $display("ERROR rd_hit_oh_o: expected %h, got %h (addr %h)", exp_hit, rd_hit, a);
      err_cnt++;
    end
    if (rd_valid !== m_vld[s]) begin
      $display("ERROR rd_valid_bits_o: expected %h, got %h (addr %h)", m_vld[s], rd_valid, a);
      err_cnt++;
    end
    if (exp_hit != '0 && rd_data !== exp_data) begin
      $display("ERROR rd_data_o: expected %h, got %h (addr %h)", exp_data, rd_data, a);
      err_cnt++;
    end
  endtask

  // Victim is the lowest invalid way or else the round-robin pointer
  task automatic fill_line(input logic [15:0] a, input logic [63:0] d);
    logic [3:0] s;
    int v;
    s = map_set(a, m_sa);
    v = -1;
    for (int w = 0; w < WAYS; w++)
      if (v < 0 && !m_vld[s][w]) v = w;
    if (v < 0) v = m_rr;
    fill = 1'b1;
    fill_addr = a;
    fill_data = d;
    @(negedge clk);
    fill = 1'b0;
    m_tag[s][v] = map_tag(a, m_sa);
    m_line[s][v] = d;
    m_vld[s][v] = 1'b1;
    m_rr = (v + 1) % WAYS;
  endtask

  task automatic write_word(input logic [15:0] a, input int way, input logic [31:0] d);
    logic [3:0] s;
    s = map_set(a, m_sa);
    wr_req_oh = WAYS'(1) << way;
    wr_addr = a;
    wr_data = d;
    @(negedge clk);
    wr_req_oh = '0;
    if (a[2]) m_line[s][way][63:32] = d;
    else m_line[s][way][31:0] = d;
  endtask

  // Setup and access phase with the result sampled mid-way through the access cycle
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err = pslverr;
    // Every transfer completes without wait states
    if (pready !== 1'b1) begin
      $display("ERROR pready_o: expected 1, got %h (paddr %h)", pready, addr);
      err_cnt++;
    end
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (err_cnt == test_err0) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s: %0d errors", name, err_cnt - test_err0);
      tests_failed++;
    end
    test_err0 = err_cnt;
  endtask

  initial begin
    logic [15:0] a;
    logic [15:0] pool[$];
    logic [15:0] fa_addr[3];
    logic [31:0] rdata;
    logic [8:0] t;
    logic [3:0] idx;
    logic perr, acked;
    int way, start;
    void'($urandom(57));
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {rd_req, fill, fill_data, wr_req_oh, wr_data} = '0;
    rd_addr = '0;
    fill_addr = '0;
    wr_addr = '0;
    {cycle_cnt, err_cnt, test_err0, tests_run, tests_failed, m_rr} = '0;
    m_sa = 1'b1;
    for (int s = 0; s < NUM_SETS; s++) m_vld[s] = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);

    // Five fills into empty set 5 where the fifth evicts the pointer's way
    for (int k = 0; k < 5; k++) begin
      fill_line({9'(k * 37 + 3), 4'd5, 3'd0}, {$urandom, $urandom});
      read_check({9'(k * 37 + 3), 4'd5, 3'd4});
    end
    read_check({9'd3, 4'd5, 3'd0});
    report_test("victim choice");

    // Random fills with reads mostly aimed at lines already filled
    for (int i = 0; i < 40; i++) begin
      a = 16'($urandom);
      if (!model_hit(a)) begin
        fill_line(a, {$urandom, $urandom});
        pool.push_back(a);
      end
      if (i % 4 == 3 || pool.size() == 0) read_check(16'($urandom));
      else read_check({pool[$urandom % pool.size()][15:3], 3'($urandom)});
    end
    report_test("set-associative lookup");

    // Word writes to hit lines with both halves read back
    for (int i = 0; i < 4; i++) begin
      a = {pool[$urandom % pool.size()][15:3], 1'($urandom), 2'b0};
      if (model_hit(a)) begin
        way = 0;
        for (int w = 0; w < WAYS; w++)
          if (m_vld[map_set(a, 1'b1)][w] && m_tag[map_set(a, 1'b1)][w] == map_tag(a, 1'b1))
            way = w;
        write_word(a, way, $urandom);
        read_check(a);
        read_check(a ^ 16'h4);
      end
    end
    report_test("word write");

    // Three indexes with the same tag all land in one hashed set
    apb_access(1'b1, REG_CTRL, 32'h0, rdata, perr);
    m_sa = 1'b0;
    t = 9'h100 | 9'($urandom);
    idx = 4'($urandom);
    fa_addr[0] = {t, idx, 3'd0};
    fa_addr[1] = {t, idx + 4'd5, 3'd4};
    fa_addr[2] = {t, idx + 4'd11, 3'd0};
    for (int i = 0; i < 3; i++) fill_line(fa_addr[i], {$urandom, $urandom});
    for (int i = 0; i < 3; i++) read_check(fa_addr[i]);
    apb_access(1'b1, REG_CTRL, 32'h1, rdata, perr);
    m_sa = 1'b1;
    for (int i = 0; i < 3; i++) begin
      read_check(fa_addr[i]);
      read_check({9'($urandom), map_set(fa_addr[i], 1'b0), 3'($urandom)});
    end
    report_test("fully-associative mode");

    // Unknown offsets error out while CTRL and STATUS read back
    apb_access(1'b1, 8'h08, 32'h5, rdata, perr);
    if (perr !== 1'b1) begin
      $display("ERROR pslverr_o: expected 1, got %h (write 08)", perr);
      err_cnt++;
    end
    apb_access(1'b0, 8'h0C, 32'h0, rdata, perr);
    if (perr !== 1'b1) begin
      $display("ERROR pslverr_o: expected 1, got %h (read 0c)", perr);
      err_cnt++;
    end
    apb_access(1'b1, REG_CTRL, 32'h0, rdata, perr);
    apb_access(1'b0, REG_CTRL, 32'h0, rdata, perr);
    if (rdata !== 32'h0 || perr !== 1'b0) begin
      $display("ERROR prdata_o: expected 00000000, got %h (pslverr %h)", rdata, perr);
      err_cnt++;
    end
    apb_access(1'b1, REG_CTRL, 32'h1, rdata, perr);
    apb_access(1'b0, REG_STATUS, 32'h0, rdata, perr);
    if (rdata !== 32'h0) begin
      $display("ERROR prdata_o: expected 00000000, got %h (idle status)", rdata);
      err_cnt++;
    end
    report_test("APB registers and error");

    // Flush keeps SA mode; busy shows in STATUS and reads are dropped meanwhile
    apb_access(1'b1, REG_CTRL, 32'h3, rdata, perr);
    start = cycle_cnt;
    apb_access(1'b0, REG_STATUS, 32'h0, rdata, perr);
    if (rdata[0] !== 1'b1) begin
      $display("ERROR prdata_o: expected busy 1, got %h", rdata);
      err_cnt++;
    end
    apb_access(1'b0, REG_CTRL, 32'h0, rdata, perr);
    if (rdata !== 32'h1) begin
      $display("ERROR prdata_o: expected 00000001, got %h (ctrl during flush)", rdata);
      err_cnt++;
    end
    rd_req = 1'b1;
    rd_addr = pool[0];
    @(negedge clk);
    rd_req = 1'b0;
    if (rd_vld !== 1'b0) begin
      $display("ERROR rd_vld_o: expected 0, got %h (read during flush)", rd_vld);
      err_cnt++;
    end
    acked = 1'b0;
    while (!acked && cycle_cnt - start <= 18) begin
      if (flush_ack === 1'b1) acked = 1'b1;
      else @(negedge clk);
    end
    if (!acked) begin
      $display("flush_ack_o did not pulse within 18 cycles of the flush start");
      err_cnt++;
    end
    for (int s = 0; s < NUM_SETS; s++) m_vld[s] = '0;
    for (int i = 0; i < 8; i++) read_check(i < 4 ? pool[i] : 16'($urandom));
    report_test("flush");

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb_clk_gen.sv ====
// Free-running 4 ns clock; reset is low for 3 cycles and released on a falling edge
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== hybche_top.sv ====
// Mode switches take effect at once; a flush clears every set and blocks reads, fills and writes
module hybche_top #(
  parameter int unsigned                  NUM_WAYS     = 4,
  parameter logic [hybche_pkg::TAG_W-1:0] HASH_SEED    = 9'h0A5,
  parameter int unsigned                  FA_BASE_SET  = 8,
  parameter int unsigned                  FA_SET_COUNT = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // APB
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [hybche_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic [hybche_pkg::APB_DATA_W-1:0] pwdata_i,
  output logic [hybche_pkg::APB_DATA_W-1:0] prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  // Lookup port
  input  logic                              rd_req_i,
  input  hybche_pkg::hybche_addr_u          rd_addr_i,
  output logic                              rd_vld_o,
  output logic [NUM_WAYS-1:0]               rd_hit_oh_o,
  output logic [NUM_WAYS-1:0]               rd_valid_bits_o,
  output logic [hybche_pkg::WORD_W-1:0]     rd_data_o,
  // Line fill
  input  logic                              fill_i,
  input  hybche_pkg::hybche_addr_u          fill_addr_i,
  input  logic [hybche_pkg::LINE_W-1:0]     fill_data_i,
  // Word write
  input  logic [NUM_WAYS-1:0]               wr_req_oh_i,
  input  hybche_pkg::hybche_addr_u          wr_addr_i,
  input  logic [hybche_pkg::WORD_W-1:0]     wr_data_i,
  // Flush done
  output logic                              flush_ack_o
);
  import hybche_pkg::*;

  logic                              sa_mode;
  logic                              flush_start;
  logic                              flush_busy;
  logic                              clr_en;
  logic [IDX_W-1:0]                  clr_idx;
  logic [IDX_W-1:0]                  rd_set;
  logic [FA_TAG_W-1:0]               rd_tag;
  logic [IDX_W-1:0]                  fill_set;
  logic [FA_TAG_W-1:0]               fill_tag;
  logic [IDX_W-1:0]                  wr_set;
  logic [NUM_WAYS-1:0][FA_TAG_W-1:0] set_tags;
  logic [NUM_WAYS-1:0]               set_valid;
  logic [NUM_WAYS-1:0][LINE_W-1:0]   set_lines;
  logic [NUM_WAYS-1:0]               fill_valid;
  logic [NUM_WAYS-1:0]               victim_oh;

  //////////////////////////////
  // Control
  //////////////////////////////

  hybche_cfg_apb i_cfg_apb (
    .clk_i, .rst_ni, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .busy_i        (flush_busy),
    .sa_mode_o     (sa_mode),
    .flush_start_o (flush_start)
  );

  hybche_flush_ctrl i_flush_ctrl (
    .clk_i, .rst_ni,
    .flush_start_i (flush_start),
    .busy_o        (flush_busy),
    .clr_en_o      (clr_en),
    .clr_idx_o     (clr_idx),
    .flush_ack_o
  );

  //////////////////////////////
  // Address mapping
  //////////////////////////////

  hybche_index_map #(
    .HASH_SEED (HASH_SEED), .FA_BASE_SET (FA_BASE_SET), .FA_SET_COUNT (FA_SET_COUNT)
  ) i_map_rd (
    .addr_i (rd_addr_i), .sa_mode_i (sa_mode), .set_o (rd_set), .tag_o (rd_tag)
  );

  // Fill set feeds both the arrays and the victim choice
  hybche_index_map #(
    .HASH_SEED (HASH_SEED), .FA_BASE_SET (FA_BASE_SET), .FA_SET_COUNT (FA_SET_COUNT)
  ) i_map_fill (
    .addr_i (fill_addr_i), .sa_mode_i (sa_mode), .set_o (fill_set), .tag_o (fill_tag)
  );

  // Word write names its way, so only the set is needed
  hybche_index_map #(
    .HASH_SEED (HASH_SEED), .FA_BASE_SET (FA_BASE_SET), .FA_SET_COUNT (FA_SET_COUNT)
  ) i_map_wr (
    .addr_i (wr_addr_i), .sa_mode_i (sa_mode), .set_o (wr_set), .tag_o ()
  );

  //////////////////////////////
  // Storage and lookup
  //////////////////////////////

  hybche_arrays #(.NUM_WAYS (NUM_WAYS)) i_arrays (
    .clk_i, .rst_ni,
    .rd_set_i      (rd_set),
    .rd_tags_o     (set_tags),
    .rd_valid_o    (set_valid),
    .rd_lines_o    (set_lines),
    .fill_i,
    .fill_set_i    (fill_set),
    .fill_tag_i    (fill_tag),
    .fill_way_oh_i (victim_oh),
    .fill_data_i,
    .fill_valid_o  (fill_valid),
    .wr_req_oh_i,
    .wr_set_i      (wr_set),
    .wr_half_i     (wr_addr_i.sa.off[OFF_W-1]),
    .wr_data_i,
    .clr_en_i      (clr_en),
    .clr_idx_i     (clr_idx)
  );

  hybche_lookup #(.NUM_WAYS (NUM_WAYS)) i_lookup (
    .clk_i, .rst_ni, .rd_req_i,
    .rd_tag_i     (rd_tag),
    .rd_half_i    (rd_addr_i.sa.off[OFF_W-1]),
    .blocked_i    (flush_busy),
    .tags_i       (set_tags),
    .valid_i      (set_valid),
    .lines_i      (set_lines),
    .fill_i,
    .valid_fill_i (fill_valid),
    .victim_oh_o  (victim_oh),
    .rd_vld_o, .rd_hit_oh_o, .rd_valid_bits_o, .rd_data_o
  );

endmodule

// ==== hybche_flush_ctrl.sv ====
// Clears one set per cycle over all sets; a start while busy is ignored
module hybche_flush_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_start_i,
  output logic                         busy_o,
  output logic                         clr_en_o,
  output logic [hybche_pkg::IDX_W-1:0] clr_idx_o,
  output logic                         flush_ack_o
);
  import hybche_pkg::*;

  localparam logic [IDX_W-1:0] LAST_SET = IDX_W'(NUM_SETS - 1);

  logic             busy_q;
  logic [IDX_W-1:0] cnt_q;
  logic             ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
      ack_q  <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Last set is cleared on this edge where busy drops and ack rises
        if (cnt_q == LAST_SET) begin
          busy_q <= 1'b0;
          ack_q  <= 1'b1;
        end
      end else if (flush_start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end
    end
  end

  // Clear strobe follows busy
  assign busy_o      = busy_q;
  assign clr_en_o    = busy_q;
  assign clr_idx_o   = cnt_q;
  assign flush_ack_o = ack_q;

endmodule

// ==== hybche_lookup.sv ====
// One-cycle read stage with a request per cycle; NUM_WAYS must be a power of two above 1
module hybche_lookup #(
  parameter int unsigned NUM_WAYS = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         rd_req_i,
  input  logic [hybche_pkg::FA_TAG_W-1:0]              rd_tag_i,
  input  logic                                         rd_half_i,
  input  logic                                         blocked_i,
  input  logic [NUM_WAYS-1:0][hybche_pkg::FA_TAG_W-1:0] tags_i,
  input  logic [NUM_WAYS-1:0]                          valid_i,
  input  logic [NUM_WAYS-1:0][hybche_pkg::LINE_W-1:0]  lines_i,
  input  logic                                         fill_i,
  input  logic [NUM_WAYS-1:0]                          valid_fill_i,
  output logic [NUM_WAYS-1:0]                          victim_oh_o,
  output logic                                         rd_vld_o,
  output logic [NUM_WAYS-1:0]                          rd_hit_oh_o,
  output logic [NUM_WAYS-1:0]                          rd_valid_bits_o,
  output logic [hybche_pkg::WORD_W-1:0]                rd_data_o
);
  import hybche_pkg::*;

  localparam int unsigned WAY_W = $clog2(NUM_WAYS);

  logic                accept;
  logic [NUM_WAYS-1:0] hit;
  logic [WORD_W-1:0]   hit_word;
  logic                inv_found;
  logic [WAY_W-1:0]    inv_way;
  logic [WAY_W-1:0]    victim_way;
  logic [WAY_W-1:0]    rr_q;
  logic                vld_q;
  logic [NUM_WAYS-1:0] hit_q;
  logic [NUM_WAYS-1:0] valid_q;
  logic [WORD_W-1:0]   data_q;

  //////////////////////////////
  // Tag compare
  //////////////////////////////

  // Requests during a flush are dropped
  assign accept = rd_req_i & ~blocked_i;

  always_comb begin
    hit      = '0;
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit[w] = valid_i[w] && (tags_i[w] == rd_tag_i);
      if (hit[w]) begin
        hit_word = rd_half_i ? lines_i[w][LINE_W-1:WORD_W] : lines_i[w][WORD_W-1:0];
      end
    end
  end

  // Result register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q   <= 1'b0;
      hit_q   <= '0;
      valid_q <= '0;
    end else begin
      vld_q <= accept;
      if (accept) begin
        hit_q   <= hit;
        valid_q <= valid_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= hit_word;
    end
  end

  assign rd_vld_o        = vld_q;
  assign rd_hit_oh_o     = hit_q;
  assign rd_valid_bits_o = valid_q;
  assign rd_data_o       = data_q;

  //////////////////////////////
  // Victim choice
  //////////////////////////////

  // Scanned downwards so the lowest invalid way wins
  always_comb begin
    inv_found = 1'b0;
    inv_way   = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_fill_i[w]) begin
        inv_found = 1'b1;
        inv_way   = WAY_W'(w);
      end
    end
  end

  assign victim_way  = inv_found ? inv_way : rr_q;
  assign victim_oh_o = NUM_WAYS'(1) << victim_way;

  // Pointer moves past the way just filled; wraps with the power-of-two width
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (fill_i && !blocked_i) begin
      rr_q <= victim_way + 1'b1;
    end
  end

endmodule

// ==== hybche_arrays.sv ====
// Asynchronous read of one set; while clearing a set all fills and word writes are dropped
module hybche_arrays #(
  parameter int unsigned NUM_WAYS = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic [hybche_pkg::IDX_W-1:0]                 rd_set_i,
  output logic [NUM_WAYS-1:0][hybche_pkg::FA_TAG_W-1:0] rd_tags_o,
  output logic [NUM_WAYS-1:0]                          rd_valid_o,
  output logic [NUM_WAYS-1:0][hybche_pkg::LINE_W-1:0]  rd_lines_o,
  input  logic                                         fill_i,
  input  logic [hybche_pkg::IDX_W-1:0]                 fill_set_i,
  input  logic [hybche_pkg::FA_TAG_W-1:0]              fill_tag_i,
  input  logic [NUM_WAYS-1:0]                          fill_way_oh_i,
  input  logic [hybche_pkg::LINE_W-1:0]                fill_data_i,
  output logic [NUM_WAYS-1:0]                          fill_valid_o,
  input  logic [NUM_WAYS-1:0]                          wr_req_oh_i,
  input  logic [hybche_pkg::IDX_W-1:0]                 wr_set_i,
  input  logic                                         wr_half_i,
  input  logic [hybche_pkg::WORD_W-1:0]                wr_data_i,
  input  logic                                         clr_en_i,
  input  logic [hybche_pkg::IDX_W-1:0]                 clr_idx_i
);
  import hybche_pkg::*;

  //////////////////////////////
  // Storage
  //////////////////////////////

  logic [NUM_WAYS-1:0][FA_TAG_W-1:0] tag_mem  [NUM_SETS];
  logic [NUM_WAYS-1:0][LINE_W-1:0]   line_mem [NUM_SETS];
  logic [NUM_WAYS-1:0]               valid_q  [NUM_SETS];

  // Lookup set
  assign rd_tags_o  = tag_mem[rd_set_i];
  assign rd_valid_o = valid_q[rd_set_i];
  assign rd_lines_o = line_mem[rd_set_i];

  // Valid bits of the fill set feed the victim choice
  assign fill_valid_o = valid_q[fill_set_i];

  // Valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
    end else if (clr_en_i) begin
      valid_q[clr_idx_i] <= '0;
    end else if (fill_i) begin
      valid_q[fill_set_i] <= valid_q[fill_set_i] | fill_way_oh_i;
    end
  end

  // Tags and lines
  always_ff @(posedge clk_i) begin
    if (clr_en_i) begin
      tag_mem[clr_idx_i]  <= '0;
      line_mem[clr_idx_i] <= '0;
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (fill_i && fill_way_oh_i[w]) begin
          tag_mem[fill_set_i][w]  <= fill_tag_i;
          line_mem[fill_set_i][w] <= fill_data_i;
        end
        // Word write comes last so it wins over a fill of the same line
        if (wr_req_oh_i[w]) begin
          line_mem[wr_set_i][w][int'(wr_half_i)*WORD_W +: WORD_W] <= wr_data_i;
        end
      end
    end
  end

endmodule

// ==== hybche_index_map.sv ====
// Combinational; FA_BASE_SET + FA_SET_COUNT must not exceed the number of sets
module hybche_index_map #(
  parameter logic [hybche_pkg::TAG_W-1:0] HASH_SEED    = 9'h0A5,
  parameter int unsigned                  FA_BASE_SET  = 8,
  parameter int unsigned                  FA_SET_COUNT = 8
) (
  input  hybche_pkg::hybche_addr_u        addr_i,
  input  logic                            sa_mode_i,
  output logic [hybche_pkg::IDX_W-1:0]    set_o,
  output logic [hybche_pkg::FA_TAG_W-1:0] tag_o
);
  import hybche_pkg::*;

  logic [TAG_W-1:0] hash;
  logic [IDX_W-1:0] fa_set;

  // Seeded hash of the tag field
  assign hash   = addr_i.sa.tag ^ HASH_SEED;
  // Fold into the reserved region of sets
  assign fa_set = IDX_W'(hash % FA_SET_COUNT) + IDX_W'(FA_BASE_SET);

  always_comb begin
    if (sa_mode_i) begin
      set_o = addr_i.sa.idx;
      // Upper tag bits stay zero in this mode
      tag_o = FA_TAG_W'(addr_i.sa.tag);
    end else begin
      set_o = fa_set;
      tag_o = addr_i.fa.tag;
    end
  end

endmodule

// ==== hybche_cfg_apb.sv ====
// Zero-wait-state APB slave; unknown offsets raise PSLVERR and a flush request while busy is ignored
module hybche_cfg_apb (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [hybche_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic [hybche_pkg::APB_DATA_W-1:0] pwdata_i,
  output logic [hybche_pkg::APB_DATA_W-1:0] prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  input  logic                              busy_i,
  output logic                              sa_mode_o,
  output logic                              flush_start_o
);
  import hybche_pkg::*;

  logic access;
  logic sel_ctrl;
  logic sel_status;
  logic ctrl_wr;
  logic mode_q;

  // Access phase of a transfer
  assign access     = psel_i & penable_i;
  assign sel_ctrl   = (paddr_i == REG_CTRL);
  assign sel_status = (paddr_i == REG_STATUS);
  assign ctrl_wr    = access & pwrite_i & sel_ctrl;

  // No wait states
  assign pready_o  = 1'b1;
  // Error only for offsets outside the map
  assign pslverr_o = access & ~(sel_ctrl | sel_status);

  // Mode bit resets to set-associative
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= 1'b1;
    end else if (ctrl_wr) begin
      mode_q <= pwdata_i[CTRL_MODE_BIT];
    end
  end

  assign sa_mode_o = mode_q;

  // Single-cycle start since the access phase lasts exactly one cycle
  assign flush_start_o = ctrl_wr & pwdata_i[CTRL_FLUSH_BIT] & ~busy_i;

  // Read mux
  always_comb begin
    prdata_o = '0;
    if (sel_ctrl) begin
      // Flush bit is self-clearing and reads back 0
      prdata_o[CTRL_MODE_BIT] = mode_q;
    end else if (sel_status) begin
      prdata_o[STATUS_BUSY_BIT] = busy_i;
    end
  end

endmodule

// ==== hybche_pkg.sv ====
// Fixed geometry of 16-bit address, 64-bit lines and 16 sets; the APB map decodes only 0x0 and 0x4
package hybche_pkg;

  //////////////////////////////
  // Address geometry
  //////////////////////////////

  localparam int unsigned ADDR_W   = 16;
  // Byte offset inside a 64-bit line
  localparam int unsigned OFF_W    = 3;
  localparam int unsigned IDX_W    = 4;
  localparam int unsigned TAG_W    = ADDR_W - IDX_W - OFF_W;
  // Fully-associative tag keeps the index bits too
  localparam int unsigned FA_TAG_W = TAG_W + IDX_W;
  localparam int unsigned LINE_W   = 64;
  localparam int unsigned WORD_W   = 32;
  localparam int unsigned NUM_SETS = 1 << IDX_W;

  // One lookup address that reads two ways depending on the cache mode
  typedef union packed {
    // Set-associative view
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] idx;
      logic [OFF_W-1:0] off;
    } sa;
    // Fully-associative view with tag and index merged
    struct packed {
      logic [FA_TAG_W-1:0] tag;
      logic [OFF_W-1:0]    off;
    } fa;
  } hybche_addr_u;

  //////////////////////////////
  // APB register map
  //////////////////////////////

  localparam int unsigned APB_ADDR_W = 8;
  localparam int unsigned APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 8'h0;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h4;

  // CTRL fields with mode 1 meaning set-associative
  localparam int unsigned CTRL_MODE_BIT   = 0;
  localparam int unsigned CTRL_FLUSH_BIT  = 1;
  // STATUS fields
  localparam int unsigned STATUS_BUSY_BIT = 0;

endpackage
